// File: rtl/exu_pkg.sv
package exu_pkg;

  localparam int xlen = 64;

  // major opcodes
  localparam logic [6:0] op_r      = 7'b0110011;
  localparam logic [6:0] op_rw     = 7'b0111011;
  localparam logic [6:0] op_i      = 7'b0010011;
  localparam logic [6:0] op_iw     = 7'b0011011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [6:0] funct7_m = 7'b0000001; // M extension

  // funct3 of register and immediate ALU forms
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // funct3 of conditional branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  typedef enum logic [4:0] {
    add, sub, and_op, or_op, xor_op, sll, srl, sra, slt, sltu, lui_pass, br_cond
  } alu_op_e;

  // encoded as funct3 of the M extension
  typedef enum logic [2:0] {
    mul, mulh, mulhsu, mulhu, div, divu, rem, remu
  } md_op_e;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } insn_u;

endpackage

// File: rtl/exu_decode.sv
`timescale 1ns/1ps

module exu_decode import exu_pkg::*; (
  input  insn_u   insn,
  input  logic    valid,
  output alu_op_e alu_op,
  output logic    word,
  output logic    use_imm,
  output logic    jalr,
  output logic    sys,
  output logic    md_req,
  output md_op_e  md_op
);

  logic [6:0] opcode;
  logic       is_reg;
  logic       is_imm;
  logic [2:0] f3;
  logic       alt;

  assign opcode = insn.r.opcode;
  assign is_reg = (opcode == op_r) || (opcode == op_rw);
  assign is_imm = (opcode == op_i) || (opcode == op_iw);

  assign f3  = insn.r.funct3;    // same field in both views
  assign alt = insn.i.imm12[10]; // funct7[5] in the R view

  always_comb begin
    alu_op = add; // auipc, load, store, jal, jalr, system
    if (is_reg || is_imm) begin
      case (f3)
        f3_add:  alu_op = (is_reg && alt) ? sub : add;
        f3_sll:  alu_op = sll;
        f3_slt:  alu_op = slt;
        f3_sltu: alu_op = sltu;
        f3_xor:  alu_op = xor_op;
        f3_sr:   alu_op = alt ? sra : srl;
        f3_or:   alu_op = or_op;
        f3_and:  alu_op = and_op;
        default: alu_op = add;
      endcase
    end else if (opcode == op_lui) begin
      alu_op = lui_pass;
    end else if (opcode == op_branch) begin
      alu_op = br_cond;
    end
  end

  assign word = (opcode == op_rw) || (opcode == op_iw);

  assign use_imm = is_imm ||
                   (opcode == op_lui)   ||
                   (opcode == op_auipc) ||
                   (opcode == op_load)  ||
                   (opcode == op_store) ||
                   (opcode == op_jal)   ||
                   (opcode == op_jalr);

  assign jalr = (opcode == op_jalr);
  assign sys  = (opcode == op_system); // result forced to zero downstream

  assign md_req = valid && is_reg && (insn.r.funct7 == funct7_m);
  assign md_op  = md_op_e'(insn.r.funct3);

endmodule

// File: rtl/exu_alu.sv
`timescale 1ns/1ps

module exu_alu import exu_pkg::*; (
  input  logic [xlen-1:0] src1,
  input  logic [xlen-1:0] src2,
  input  logic [xlen-1:0] imm,
  input  alu_op_e         alu_op,
  input  logic            word,
  input  logic            use_imm,
  input  logic [2:0]      funct3,
  output logic [xlen-1:0] alu_result
);

  logic [xlen-1:0] op_b;
  logic [5:0]      shamt;
  logic [31:0]     lo_a;
  logic [xlen-1:0] sra_full;
  logic [31:0]     sra_word;
  logic            eq;
  logic            lt;
  logic            ltu;
  logic            taken;

  assign op_b  = use_imm ? imm : src2;
  assign shamt = word ? {1'b0, op_b[4:0]} : op_b[5:0]; // 5 bits for word shifts
  assign lo_a  = src1[31:0];

  // kept apart so the shift stays arithmetic
  assign sra_full = $signed(src1) >>> shamt;
  assign sra_word = $signed(lo_a) >>> shamt[4:0];

  assign eq  = (src1 == op_b);
  assign lt  = ($signed(src1) < $signed(op_b));
  assign ltu = (src1 < op_b);

  always_comb begin
    case (funct3)
      f3_beq:  taken = eq;
      f3_bne:  taken = !eq;
      f3_blt:  taken = lt;
      f3_bge:  taken = !lt;
      f3_bltu: taken = ltu;
      f3_bgeu: taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  // word results only need a correct low half, bit 31 is extended later
  always_comb begin
    case (alu_op)
      add:    alu_result = src1 + op_b;
      sub:    alu_result = src1 - op_b;
      and_op: alu_result = src1 & op_b;
      or_op:  alu_result = src1 | op_b;
      xor_op: alu_result = src1 ^ op_b;
      sll: begin
        if (word) begin
          alu_result = {32'b0, lo_a << shamt[4:0]};
        end else begin
          alu_result = src1 << shamt;
        end
      end
      srl: begin
        if (word) begin
          alu_result = {32'b0, lo_a >> shamt[4:0]};
        end else begin
          alu_result = src1 >> shamt;
        end
      end
      sra: begin
        if (word) begin
          alu_result = {32'b0, sra_word};
        end else begin
          alu_result = sra_full;
        end
      end
      slt:      alu_result = {{(xlen-1){1'b0}}, lt};
      sltu:     alu_result = {{(xlen-1){1'b0}}, ltu};
      lui_pass: alu_result = imm;
      br_cond:  alu_result = {{(xlen-1){1'b0}}, taken};
      default:  alu_result = '0;
    endcase
  end

endmodule

// File: rtl/exu_muldiv.sv
`timescale 1ns/1ps

module exu_muldiv import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            md_req,
  input  md_op_e          md_op,
  input  logic            word,
  input  logic [xlen-1:0] src1,
  input  logic [xlen-1:0] src2,
  output logic            done,
  output logic [xlen-1:0] md_result
);

  logic            busy_q;
  logic            done_q;
  logic [6:0]      cnt_q;
  md_op_e          op_q;
  logic            word_q;
  logic            neg_q;   // product or quotient sign
  logic            neg_r_q; // remainder takes the dividend sign
  logic [127:0]    acc_q;   // product, or remainder:quotient
  logic [xlen-1:0] dvs_q;   // multiplicand or divisor

  logic            is_div;
  logic            a_signed;
  logic            b_signed;
  logic [xlen-1:0] ext_a;
  logic [xlen-1:0] ext_b;
  logic            neg_a;
  logic            neg_b;
  logic [xlen-1:0] mag_a;
  logic [xlen-1:0] mag_b;
  logic            div_zero;
  logic            div_ovf;
  logic            special;
  logic [64:0]     mul_sum;
  logic [65:0]     div_diff;
  logic [127:0]    prod_fin;
  logic [xlen-1:0] quo_fin;
  logic [xlen-1:0] rem_fin;

  assign is_div   = md_op[2];
  assign a_signed = (md_op == mulh) || (md_op == mulhsu) || (md_op == div) || (md_op == rem);
  assign b_signed = (md_op == mulh) || (md_op == div) || (md_op == rem);

  assign ext_a = !word ? src1 : a_signed ? {{32{src1[31]}}, src1[31:0]} : {32'b0, src1[31:0]};
  assign ext_b = !word ? src2 : b_signed ? {{32{src2[31]}}, src2[31:0]} : {32'b0, src2[31:0]};

  assign neg_a = a_signed & ext_a[xlen-1];
  assign neg_b = b_signed & ext_b[xlen-1];
  assign mag_a = neg_a ? -ext_a : ext_a;
  assign mag_b = neg_b ? -ext_b : ext_b;

  assign div_zero = is_div && (ext_b == '0);
  assign div_ovf  = is_div && b_signed && (ext_b == '1) &&
                    (ext_a == (word ? 64'hffff_ffff_8000_0000 : 64'h8000_0000_0000_0000));
  assign special  = div_zero || div_ovf;

  // one radix-2 step each
  assign mul_sum  = {1'b0, acc_q[127:64]} + (acc_q[0] ? {1'b0, dvs_q} : 65'd0);
  assign div_diff = {1'b0, acc_q[127:63]} - {2'b00, dvs_q};

  assign prod_fin = neg_q ? -acc_q : acc_q;
  assign quo_fin  = neg_q ? -acc_q[63:0] : acc_q[63:0];
  assign rem_fin  = neg_r_q ? -acc_q[127:64] : acc_q[127:64];

  always_comb begin
    case (op_q)
      mul:                 md_result = word_q ? prod_fin[95:32] : prod_fin[63:0];
      mulh, mulhsu, mulhu: md_result = prod_fin[127:64];
      div, divu:           md_result = quo_fin;
      default:             md_result = rem_fin;
    endcase
  end

  assign done = done_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= 7'd0;
    end else if (done_q) begin
      done_q <= 1'b0; // back to idle, held md_req ignored
    end else if (busy_q) begin
      cnt_q <= cnt_q - 7'd1;
      if (cnt_q == 7'd1) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end else if (md_req) begin
      busy_q <= !special;
      done_q <= special;
      cnt_q  <= word ? 7'd32 : 7'd64;
    end
  end

  always_ff @(posedge clk) begin
    if (busy_q) begin
      if (op_q[2]) begin
        acc_q <= div_diff[65] ? {acc_q[126:0], 1'b0} : {div_diff[63:0], acc_q[62:0], 1'b1};
      end else begin
        acc_q <= {mul_sum, acc_q[63:1]};
      end
    end else if (md_req && !done_q) begin
      op_q    <= md_op;
      word_q  <= word;
      neg_q   <= (neg_a ^ neg_b) && !special;
      neg_r_q <= neg_a && !special;
      dvs_q   <= is_div ? mag_b : mag_a;
      if (div_zero) begin
        acc_q <= {ext_a, {xlen{1'b1}}};
      end else if (div_ovf) begin
        acc_q <= {{xlen{1'b0}}, ext_a};
      end else if (is_div) begin
        acc_q <= {{xlen{1'b0}}, word ? {mag_a[31:0], 32'b0} : mag_a}; // dividend at top
      end else begin
        acc_q <= {{xlen{1'b0}}, mag_b};
      end
    end
  end

endmodule

// File: rtl/exu_result_sel.sv
`timescale 1ns/1ps

module exu_result_sel import exu_pkg::*; (
  input  logic [xlen-1:0] alu_result,
  input  logic [xlen-1:0] md_result,
  input  logic            md_req,
  input  logic            done,
  input  logic            word,
  input  logic            jalr,
  input  logic            sys,
  output logic [xlen-1:0] result,
  output logic            stall
);

  logic [xlen-1:0] picked;
  logic [xlen-1:0] extended;

  always_comb begin
    if (sys) begin
      picked = '0; // system ops write back nothing
    end else if (md_req) begin
      picked = md_result;
    end else begin
      picked = alu_result;
    end
  end

  assign extended = word ? {{32{picked[31]}}, picked[31:0]} : picked;
  assign result   = jalr ? {extended[xlen-1:1], 1'b0} : extended;

  // upstream holds its inputs until the unit answers
  assign stall = md_req & ~done;

endmodule

// File: rtl/exu_top.sv
`timescale 1ns/1ps

module exu_top import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic [31:0]     insn,
  input  logic            valid,
  input  logic [xlen-1:0] src1,
  input  logic [xlen-1:0] src2,
  input  logic [xlen-1:0] imm,
  output logic [xlen-1:0] result,
  output logic            stall
);

  insn_u           insn_w;
  alu_op_e         alu_op;
  md_op_e          md_op;
  logic            word;
  logic            use_imm;
  logic            jalr;
  logic            sys;
  logic            md_req;
  logic            done;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] md_result;

  assign insn_w = insn;

  exu_decode u_decode (
    .insn    (insn_w),
    .valid   (valid),
    .alu_op  (alu_op),
    .word    (word),
    .use_imm (use_imm),
    .jalr    (jalr),
    .sys     (sys),
    .md_req  (md_req),
    .md_op   (md_op)
  );

  exu_alu u_alu (
    .src1       (src1),
    .src2       (src2),
    .imm        (imm),
    .alu_op     (alu_op),
    .word       (word),
    .use_imm    (use_imm),
    .funct3     (insn_w.r.funct3),
    .alu_result (alu_result)
  );

  exu_muldiv u_muldiv (
    .clk       (clk),
    .rst       (rst),
    .md_req    (md_req),
    .md_op     (md_op),
    .word      (word),
    .src1      (src1),
    .src2      (src2),
    .done      (done),
    .md_result (md_result)
  );

  exu_result_sel u_result_sel (
    .alu_result (alu_result),
    .md_result  (md_result),
    .md_req     (md_req),
    .done       (done),
    .word       (word),
    .jalr       (jalr),
    .sys        (sys),
    .result     (result),
    .stall      (stall)
  );

endmodule

// File: test/exu_assertions.sv
`timescale 1ns/1ps

module exu_assertions import exu_pkg::*; (
  input logic        clk,
  input logic        rst,
  input logic [31:0] insn,
  input logic        valid,
  input logic [63:0] src1,
  input logic [63:0] src2,
  input logic [63:0] imm,
  input logic [63:0] result,
  input logic        stall
);

  logic [6:0]  opc;
  logic        is_m;
  logic [63:0] exp_alu;
  logic [63:0] exp_md;
  int          run_len;
  logic        fail_alu = 1'b0;
  logic        fail_md = 1'b0;
  logic        fail_stall = 1'b0;
  logic        fail_any;

  function automatic logic [63:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  // ISA rules for everything that is not an M instruction
  function automatic logic [63:0] alu_model(input logic [31:0] ins, input logic [63:0] a,
                                            input logic [63:0] b_reg, input logic [63:0] iv);
    logic [6:0]  op;
    logic [2:0]  f3;
    logic        alt;
    logic        w;
    logic [63:0] b;
    logic [5:0]  sh;
    logic [63:0] r;
    op  = ins[6:0];
    f3  = ins[14:12];
    alt = ins[30]; // funct7[5] or imm[10]
    w   = (op == op_rw) || (op == op_iw);
    b   = ((op == op_i) || (op == op_iw)) ? iv : b_reg;
    sh  = w ? {1'b0, b[4:0]} : b[5:0];
    r   = '0;
    if ((op == op_r) || (op == op_rw) || (op == op_i) || (op == op_iw)) begin
      case (f3)
        3'd0: r = (alt && ((op == op_r) || (op == op_rw))) ? a - b : a + b;
        3'd1: r = w ? {32'b0, a[31:0] << sh} : a << sh;
        3'd2: r = {63'b0, $signed(a) < $signed(b)};
        3'd3: r = {63'b0, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
          if (w) begin
            r = alt ? {32'b0, $signed(a[31:0]) >>> sh} : {32'b0, a[31:0] >> sh};
          end else if (alt) begin
            r = $signed(a) >>> sh;
          end else begin
            r = a >> sh;
          end
        end
        3'd6: r = a | b;
        default: r = a & b;
      endcase
      if (w) r = sext32(r[31:0]);
    end else if (op == op_lui) begin
      r = iv;
    end else if (op == op_jalr) begin
      r = (a + iv) & ~64'd1;
    end else if (op == op_branch) begin
      case (f3)
        3'd0: r = {63'b0, a == b_reg};
        3'd1: r = {63'b0, a != b_reg};
        3'd4: r = {63'b0, $signed(a) < $signed(b_reg)};
        3'd5: r = {63'b0, $signed(a) >= $signed(b_reg)};
        3'd6: r = {63'b0, a < b_reg};
        3'd7: r = {63'b0, a >= b_reg};
        default: r = '0;
      endcase
    end else if (op != op_system) begin
      r = a + iv; // auipc, load, store, jal
    end
    return r;
  endfunction

  function automatic logic [63:0] md_model(input logic [31:0] ins, input logic [63:0] a,
                                           input logic [63:0] b);
    logic         w;
    logic [63:0]  x;
    logic [63:0]  y;
    logic [127:0] p;
    logic [63:0]  r;
    w = (ins[6:0] == op_rw);
    case (ins[14:12])
      3'd0: begin
        p = {64'b0, a} * {64'b0, b};
        r = p[63:0];
      end
      3'd1: begin
        p = {{64{a[63]}}, a} * {{64{b[63]}}, b};
        r = p[127:64];
      end
      3'd2: begin
        p = {{64{a[63]}}, a} * {64'b0, b};
        r = p[127:64];
      end
      3'd3: begin
        p = {64'b0, a} * {64'b0, b};
        r = p[127:64];
      end
      3'd4, 3'd6: begin
        x = w ? sext32(a[31:0]) : a;
        y = w ? sext32(b[31:0]) : b;
        if (y == '0) r = ins[13] ? x : '1;
        else if (x == 64'h8000_0000_0000_0000 && y == '1) r = ins[13] ? '0 : x;
        else r = ins[13] ? $signed(x) % $signed(y) : $signed(x) / $signed(y);
      end
      default: begin
        x = w ? {32'b0, a[31:0]} : a;
        y = w ? {32'b0, b[31:0]} : b;
        if (y == '0) r = ins[13] ? x : '1;
        else r = ins[13] ? x % y : x / y;
      end
    endcase
    if (w) r = sext32(r[31:0]);
    return r;
  endfunction

  assign opc      = insn[6:0];
  assign is_m     = ((opc == op_r) || (opc == op_rw)) && (insn[31:25] == funct7_m);
  assign exp_alu  = alu_model(insn, src1, src2, imm);
  assign exp_md   = md_model(insn, src1, src2);
  assign fail_any = fail_alu | fail_md | fail_stall;

  always @(posedge clk) begin
    if (rst) run_len <= 0;
    else run_len <= stall ? run_len + 1 : 0;
  end

  assert property (@(posedge clk) disable iff (rst)
                   (valid && !stall && !is_m) |-> result == exp_alu)
    else begin
      fail_alu = 1'b1;
      $error("CHECK FAILED result: got %h expected %h", $sampled(result), $sampled(exp_alu));
    end

  // done follows a stall for every M instruction
  assert property (@(posedge clk) disable iff (rst)
                   (valid && !stall && is_m) |-> (result == exp_md) && $past(stall))
    else begin
      fail_md = 1'b1;
      $error("CHECK FAILED result: got %h expected %h", $sampled(result), $sampled(exp_md));
    end

  assert property (@(posedge clk) $fell(rst) |-> !stall)
    else begin
      fail_stall = 1'b1;
      $error("CHECK FAILED stall: got %h expected %h after reset", $sampled(stall), 1'b0);
    end

  assert property (@(posedge clk) disable iff (rst) stall |-> (valid && is_m))
    else begin
      fail_stall = 1'b1;
      $error("CHECK FAILED stall: got %h expected %h", $sampled(stall), 1'b0);
    end

  assert property (@(posedge clk) disable iff (rst) run_len <= 65)
    else begin
      fail_stall = 1'b1;
      $error("stall stayed high for more than 65 cycles");
    end

endmodule

bind exu_top exu_assertions chk (.*);

// File: test/exu_tb.sv
`timescale 1ns/1ps

module exu_tb import exu_pkg::*;;

  localparam int n_insn     = 400;
  localparam int max_cycles = n_insn * 66 + 100;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] insn;
  logic        valid;
  logic [63:0] src1;
  logic [63:0] src2;
  logic [63:0] imm;
  logic [63:0] result;
  logic        stall;
  int          cycles = 0;

  exu_top DUT (.*);

  always #5 clk = ~clk;

  always @(negedge clk) begin
    cycles <= cycles + 1;
    if (DUT.chk.fail_any) begin
      $display("Simulation finished: FAIL");
      $fatal(1, "assertion failure");
    end else if (cycles >= max_cycles) begin
      $display("Simulation finished: FAIL");
      $fatal(1, "timeout: no progress after %0d cycles", cycles);
    end
  end

  function automatic logic [63:0] pick_operand();
    case ($urandom % 7)
      0: return 64'd0;
      1: return '1;
      2: return 64'h8000_0000_0000_0000;
      3: return 64'hffff_ffff_8000_0000; // word most negative
      default: return {$urandom, $urandom};
    endcase
  endfunction

  function automatic logic [2:0] pick_word_f3(input logic m_ext);
    if (m_ext) return ($urandom % 5 == 0) ? 3'd0 : 3'(4 + $urandom % 4);
    case ($urandom % 3)
      0: return 3'd0;
      1: return 3'd1;
      default: return 3'd5;
    endcase
  endfunction

  task automatic drive_random();
    insn_u w;
    int    kind;
    w           = {$urandom};
    kind        = int'($urandom % 12);
    src1        = pick_operand();
    src2        = pick_operand();
    imm         = {$urandom, $urandom};
    w.r.funct7  = '0;
    case (kind)
      0, 1: begin
        w.r.opcode = (kind == 0) ? op_r : op_rw;
        if (kind == 1) w.r.funct3 = pick_word_f3(1'b0);
        if (w.r.funct3 == 3'd0 || w.r.funct3 == 3'd5) w.r.funct7 = $urandom % 2 ? 7'h20 : 7'h00;
      end
      2, 3, 11: begin
        w.r.opcode = op_r;
        w.r.funct7 = funct7_m;
      end
      4: begin
        w.r.opcode = op_rw;
        w.r.funct7 = funct7_m;
        w.r.funct3 = pick_word_f3(1'b1);
      end
      5, 6: begin
        w.i.opcode = (kind == 5) ? op_i : op_iw;
        if (kind == 6) w.i.funct3 = pick_word_f3(1'b0);
        if (w.i.funct3 == 3'd1 || w.i.funct3 == 3'd5) begin
          w.i.imm12[11:6] = (w.i.funct3 == 3'd5 && $urandom % 2 == 1) ? 6'h10 : 6'h00;
          if (kind == 6) w.i.imm12[5] = 1'b0;
        end
        imm = {{52{w.i.imm12[11]}}, w.i.imm12};
      end
      7: w.r.opcode = op_lui;
      8: begin
        case ($urandom % 5)
          0: w.r.opcode = op_auipc;
          1: w.r.opcode = op_load;
          2: w.r.opcode = op_store;
          3: w.r.opcode = op_jal;
          default: w.r.opcode = op_jalr;
        endcase
      end
      9: begin
        w.r.opcode = op_branch;
        w.r.funct3 = ($urandom % 3 == 0) ? 3'(2 + $urandom % 2) ^ 3'd6 : 3'($urandom);
        if (w.r.funct3 == 3'd2 || w.r.funct3 == 3'd3) w.r.funct3 = 3'd0;
        if ($urandom % 4 == 0) src2 = src1; // equal operands
      end
      default: w.r.opcode = op_system;
    endcase
    insn  = w;
    valid = 1'b1;
  endtask

  initial begin
    void'($urandom(72222));
    rst   = 1'b1;
    insn  = 32'h0000_0013;
    valid = 1'b0;
    src1  = '0;
    src2  = '0;
    imm   = '0;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    @(posedge clk); // idle cycle right after reset
    #1;
    for (int n = 0; n < n_insn; n++) begin
      drive_random();
      do @(negedge clk); while (stall); // held until the unit answers
      @(posedge clk);
      #1;
    end
    valid = 1'b0;
    repeat (3) @(posedge clk);
    if (DUT.chk.fail_any) begin
      $display("Simulation finished: FAIL");
      $fatal(1, "assertion failure");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// File: compile.f
rtl/exu_pkg.sv
rtl/exu_decode.sv
rtl/exu_alu.sv
rtl/exu_muldiv.sv
rtl/exu_result_sel.sv
rtl/exu_top.sv
test/exu_assertions.sv
test/exu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= exu_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f compile.f
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
